// ==== src/bus_types_pkg.sv ====
// Widths, word types and FSM encodings shared by the memory subsystem
`default_nettype none

package bus_types_pkg;

  // ==============================
  // Widths
  // ==============================

  localparam int unsigned ADDR_WIDTH     = 32;
  localparam int unsigned DATA_WIDTH     = 32;
  localparam int unsigned RAM_DEPTH      = 4096;
  localparam int unsigned RAM_ADDR_WIDTH = 12;
  localparam int unsigned APB_ADDR_WIDTH = 13;

  // Byte address on the core side
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  // Full data word, no byte lanes
  typedef logic [DATA_WIDTH-1:0] word_t;
  // Physical word index into the RAM array
  typedef logic [RAM_ADDR_WIDTH-1:0] ram_addr_t;
  // Address seen by the debug module
  typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;

  // ==============================
  // FSM encodings
  // ==============================

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_t;

  // Owner of the single RAM port in a given cycle
  typedef enum logic [1:0] {
    GRANT_NONE,
    GRANT_DATA_WR,
    GRANT_DATA_RD,
    GRANT_FETCH
  } ram_grant_t;

endpackage

`default_nettype wire

// ==== src/soc_map_pkg.sv ====
// Address map of the memory subsystem as seen from the core
// Byte addresses; RAM alias decode assumes a 16 KB RAM window
`default_nettype none

package soc_map_pkg;

  // ==============================
  // Program RAM
  // ==============================

  // First and last byte of the linear RAM window
  localparam logic [31:0] RAM_BASE_ADDR = 32'h0001_0000;
  localparam logic [31:0] RAM_END_ADDR  = 32'h0001_3FFF;

  // Low address bits that select a byte inside the 16 KB RAM
  localparam int unsigned RAM_ALIAS_SHIFT = 14;

  // Upper bits 31:14 all set select the wrap-around alias
  // 0xFFFFC000 up to 0xFFFFFFFF map onto the same RAM words
  localparam logic [31-RAM_ALIAS_SHIFT:0] RAM_ALIAS_TAG = 18'h3_FFFF;

  // ==============================
  // Debug module window
  // ==============================

  // Progbuf, debug ROM and flag area of the external debug module
  // Only reachable while the core runs in debug mode
  localparam logic [31:0] DEBUG_AREA_START = 32'h0000_0200;
  localparam logic [31:0] DEBUG_AREA_END   = 32'h0000_0FFF;

  // ==============================
  // Test support
  // ==============================

  // Writes here end up in the tohost register
  localparam logic [31:0] TOHOST_ADDR = 32'h8000_1000;

endpackage

`default_nettype wire

// ==== src/addr_decoder.sv ====
// Pure combinational decode; unmapped addresses raise no flag at all
// Debug window hits count only while i_debug_mode is high
`timescale 1ns/10ps
`default_nettype none

module addr_decoder (
  input  wire bus_types_pkg::addr_t i_imem_addr,
  input  wire bus_types_pkg::addr_t i_dmem_addr,
  input  wire logic                 i_debug_mode,
  output logic                      o_imem_in_ram,
  output logic                      o_dmem_in_ram,
  output logic                      o_dmem_in_debug,
  output logic                      o_dmem_is_tohost,
  output bus_types_pkg::ram_addr_t  o_imem_word,
  output bus_types_pkg::ram_addr_t  o_dmem_word
);

  import bus_types_pkg::*;
  import soc_map_pkg::*;

  // Alias region 0xFFFFC000..0xFFFFFFFF
  function automatic logic is_alias(input addr_t addr);
    return addr[ADDR_WIDTH-1:RAM_ALIAS_SHIFT] == RAM_ALIAS_TAG;
  endfunction

  // Linear window or its alias
  function automatic logic is_ram(input addr_t addr);
    return ((addr >= RAM_BASE_ADDR) && (addr <= RAM_END_ADDR)) || is_alias(addr);
  endfunction

  // Byte address to physical word index
  function automatic ram_addr_t to_word(input addr_t addr);
    addr_t phys;
    // Alias keeps only the in-RAM offset bits
    if (is_alias(addr))
      phys = {{(ADDR_WIDTH-RAM_ALIAS_SHIFT){1'b0}}, addr[RAM_ALIAS_SHIFT-1:0]};
    else
      phys = addr - RAM_BASE_ADDR;
    return phys[RAM_ADDR_WIDTH+1:2];
  endfunction

  // ==============================
  // Region flags
  // ==============================

  assign o_imem_in_ram = is_ram(i_imem_addr);
  assign o_dmem_in_ram = is_ram(i_dmem_addr);

  assign o_dmem_in_debug = i_debug_mode &&
                           (i_dmem_addr >= DEBUG_AREA_START) &&
                           (i_dmem_addr <= DEBUG_AREA_END);

  assign o_dmem_is_tohost = (i_dmem_addr == TOHOST_ADDR);

  // Word indices are meaningful only with the matching in_ram flag
  assign o_imem_word = to_word(i_imem_addr);
  assign o_dmem_word = to_word(i_dmem_addr);

endmodule

`default_nettype wire

// ==== src/unified_ram.sv ====
// Single-port 4096 x 32 RAM shared by fetch and data, one access per cycle
// Read data returns 2 cycles after the granting edge; contents are not initialized
`timescale 1ns/10ps
`default_nettype none

module unified_ram (
  input  wire logic                      clk,
  input  wire logic                      reset_n,
  // Fetch side, read only
  input  wire logic                      i_fetch_req,
  input  wire bus_types_pkg::ram_addr_t  i_fetch_word,
  // Data side
  input  wire logic                      i_data_wr,
  input  wire logic                      i_data_rd,
  input  wire bus_types_pkg::ram_addr_t  i_data_word,
  input  wire bus_types_pkg::word_t      i_data_wdata,
  // Read returns
  output bus_types_pkg::word_t           o_fetch_rdata,
  output logic                           o_fetch_rvalid,
  output bus_types_pkg::word_t           o_data_rdata,
  output logic                           o_data_rvalid
);

  import bus_types_pkg::*;

  // Storage
  word_t mem [0:RAM_DEPTH-1];

  // Grant of this cycle and of the previous one
  ram_grant_t grant;
  ram_grant_t grant_q;

  // A port counts as busy from the accepting edge until its valid pulse is over
  logic fetch_busy;
  logic data_busy;

  ram_addr_t ram_addr;
  // Array output register, first read stage
  word_t     rd_q;

  // ==============================
  // Arbitration
  // ==============================

  // Read in first stage, or valid pulse on the output
  assign fetch_busy = (grant_q == GRANT_FETCH) || o_fetch_rvalid;
  assign data_busy  = (grant_q == GRANT_DATA_RD) || o_data_rvalid;

  // Data write, then data read, then fetch
  always_comb
  begin
    grant = GRANT_NONE;
    if (i_data_wr)
      grant = GRANT_DATA_WR;
    else if (i_data_rd && !data_busy)
      grant = GRANT_DATA_RD;
    else if (i_fetch_req && !fetch_busy)
      grant = GRANT_FETCH;
  end

  assign ram_addr = (grant == GRANT_FETCH) ? i_fetch_word : i_data_word;

  // ==============================
  // Array access
  // ==============================

  always_ff @(posedge clk)
  begin
    if (grant == GRANT_DATA_WR)
      mem[ram_addr] <= i_data_wdata;
    else if (grant != GRANT_NONE)
      rd_q <= mem[ram_addr];
  end

  // Remember who owns the word now sitting in rd_q
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      grant_q <= GRANT_NONE;
    else
      grant_q <= grant;
  end

  // ==============================
  // Return routing
  // ==============================

  // Second stage, one cycle valid pulse per accepted read
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      o_fetch_rvalid <= 1'b0;
      o_data_rvalid  <= 1'b0;
    end
    else
    begin
      o_fetch_rvalid <= (grant_q == GRANT_FETCH);
      o_data_rvalid  <= (grant_q == GRANT_DATA_RD);
    end
  end

  // Returned words stay put until the next read of the same port
  always_ff @(posedge clk)
  begin
    case (grant_q)
      GRANT_FETCH:   o_fetch_rdata <= rd_q;
      GRANT_DATA_RD: o_data_rdata  <= rd_q;
      default:
      begin
        // Writes and idle cycles leave both returns unchanged
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/debug_apb_master.sv ====
// APB master toward the debug module, one transfer at a time, no byte strobes
// An error response ends the transfer silently; leaving debug mode aborts it
`timescale 1ns/10ps
`default_nettype none

module debug_apb_master (
  input  wire logic                      clk,
  input  wire logic                      reset_n,
  input  wire logic                      i_debug_mode,
  // Requests from the data port, held until done
  input  wire logic                      i_req_rd,
  input  wire logic                      i_req_wr,
  input  wire bus_types_pkg::apb_addr_t  i_req_addr,
  input  wire bus_types_pkg::word_t      i_req_wdata,
  // APB master side
  output bus_types_pkg::apb_addr_t       o_apb_paddr,
  output logic                           o_apb_psel,
  output logic                           o_apb_penable,
  output logic                           o_apb_pwrite,
  output bus_types_pkg::word_t           o_apb_pwdata,
  input  wire logic                      i_apb_pready,
  input  wire bus_types_pkg::word_t      i_apb_prdata,
  input  wire logic                      i_apb_pslverr,
  // Completion toward the data port
  output logic                           o_rd_done,
  output logic                           o_wr_done,
  output bus_types_pkg::word_t           o_rd_data
);

  import bus_types_pkg::*;

  apb_state_t state;
  apb_state_t state_next;

  logic      req_any;
  logic      xfer_end;
  // Transfer captured in APB_IDLE
  apb_addr_t addr_q;
  word_t     wdata_q;
  logic      write_q;
  // Last word read back
  word_t     rd_data_q;

  assign req_any = i_req_rd || i_req_wr;

  // Transfer leaves ACCESS on ready or on error
  assign xfer_end = (state == APB_ACCESS) && (i_apb_pready || i_apb_pslverr);

  // ==============================
  // FSM
  // ==============================

  always_comb
  begin
    state_next = state;
    case (state)
      APB_IDLE:
        if (req_any)
          state_next = APB_SETUP;
      APB_SETUP:
        state_next = APB_ACCESS;
      APB_ACCESS:
        // Wait states keep us here
        if (xfer_end)
          state_next = APB_IDLE;
      default:
        state_next = APB_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state   <= APB_IDLE;
      write_q <= 1'b0;
    end
    else if (!i_debug_mode)
      // Dropping out of debug mode abandons any transfer
      state <= APB_IDLE;
    else
    begin
      state <= state_next;
      // Writes win if both requests were ever high together
      if ((state == APB_IDLE) && req_any)
        write_q <= i_req_wr;
    end
  end

  // Address and write data for the whole SETUP/ACCESS sequence
  always_ff @(posedge clk)
  begin
    if ((state == APB_IDLE) && req_any)
    begin
      addr_q  <= i_req_addr;
      wdata_q <= i_req_wdata;
    end
  end

  // ==============================
  // Bus outputs and completion
  // ==============================

  assign o_apb_psel    = (state != APB_IDLE);
  assign o_apb_penable = (state == APB_ACCESS);
  assign o_apb_paddr   = addr_q;
  assign o_apb_pwrite  = write_q;
  assign o_apb_pwdata  = wdata_q;

  // Good completions only; errors give no pulse
  assign o_rd_done = (state == APB_ACCESS) && i_apb_pready && !i_apb_pslverr && !write_q;
  assign o_wr_done = (state == APB_ACCESS) && i_apb_pready && !i_apb_pslverr && write_q;

  always_ff @(posedge clk)
  begin
    if (o_rd_done)
      rd_data_q <= i_apb_prdata;
  end

  // Live data in the completing cycle, held copy afterwards
  assign o_rd_data = o_rd_done ? i_apb_prdata : rd_data_q;

endmodule

`default_nettype wire

// ==== src/mem_subsystem_top.sv ====
// Memory subsystem between a RISC-V core and its RAM, debug module and tohost
// Unmapped accesses get no response; writes are whole words
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem_top (
  input  wire logic                      clk,
  input  wire logic                      reset_n,
  // Fetch port
  input  wire bus_types_pkg::addr_t      i_imem_addr,
  input  wire logic                      i_imem_rready,
  output bus_types_pkg::word_t           o_imem_rdata,
  output logic                           o_imem_rvalid,
  // Data port
  input  wire bus_types_pkg::addr_t      i_dmem_addr,
  input  wire bus_types_pkg::word_t      i_dmem_wdata,
  input  wire logic                      i_dmem_wvalid,
  input  wire logic                      i_dmem_rready,
  output logic                           o_dmem_wready,
  output bus_types_pkg::word_t           o_dmem_rdata,
  output logic                           o_dmem_rvalid,
  // APB toward the debug module
  output bus_types_pkg::apb_addr_t       o_apb_paddr,
  output logic                           o_apb_psel,
  output logic                           o_apb_penable,
  output logic                           o_apb_pwrite,
  output bus_types_pkg::word_t           o_apb_pwdata,
  input  wire logic                      i_apb_pready,
  input  wire bus_types_pkg::word_t      i_apb_prdata,
  input  wire logic                      i_apb_pslverr,
  // Core status and test output
  input  wire logic                      i_debug_mode,
  output bus_types_pkg::word_t           o_tohost
);

  import bus_types_pkg::*;

  // Decode results
  logic      imem_in_ram;
  logic      dmem_in_ram;
  logic      dmem_in_debug;
  logic      dmem_is_tohost;
  ram_addr_t imem_word;
  ram_addr_t dmem_word;

  // Gated requests
  logic      fetch_req;
  logic      ram_wr;
  logic      ram_rd;
  logic      apb_rd;
  logic      apb_wr;

  // Returns
  word_t     fetch_rdata;
  logic      fetch_rvalid;
  word_t     ram_rdata;
  logic      ram_rvalid;
  word_t     apb_rdata;
  logic      apb_rd_done;
  logic      apb_wr_done;

  addr_decoder decoder_i (
    .i_imem_addr      (i_imem_addr),
    .i_dmem_addr      (i_dmem_addr),
    .i_debug_mode     (i_debug_mode),
    .o_imem_in_ram    (imem_in_ram),
    .o_dmem_in_ram    (dmem_in_ram),
    .o_dmem_in_debug  (dmem_in_debug),
    .o_dmem_is_tohost (dmem_is_tohost),
    .o_imem_word      (imem_word),
    .o_dmem_word      (dmem_word)
  );

  // ==============================
  // Request gating
  // ==============================

  assign fetch_req = i_imem_rready && imem_in_ram;
  assign ram_wr    = i_dmem_wvalid && dmem_in_ram;
  assign ram_rd    = i_dmem_rready && dmem_in_ram;
  assign apb_wr    = i_dmem_wvalid && dmem_in_debug;
  assign apb_rd    = i_dmem_rready && dmem_in_debug;

  unified_ram ram_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_fetch_req    (fetch_req),
    .i_fetch_word   (imem_word),
    .i_data_wr      (ram_wr),
    .i_data_rd      (ram_rd),
    .i_data_word    (dmem_word),
    .i_data_wdata   (i_dmem_wdata),
    .o_fetch_rdata  (fetch_rdata),
    .o_fetch_rvalid (fetch_rvalid),
    .o_data_rdata   (ram_rdata),
    .o_data_rvalid  (ram_rvalid)
  );

  debug_apb_master apb_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_debug_mode  (i_debug_mode),
    .i_req_rd      (apb_rd),
    .i_req_wr      (apb_wr),
    .i_req_addr    (i_dmem_addr[APB_ADDR_WIDTH-1:0]),
    .i_req_wdata   (i_dmem_wdata),
    .o_apb_paddr   (o_apb_paddr),
    .o_apb_psel    (o_apb_psel),
    .o_apb_penable (o_apb_penable),
    .o_apb_pwrite  (o_apb_pwrite),
    .o_apb_pwdata  (o_apb_pwdata),
    .i_apb_pready  (i_apb_pready),
    .i_apb_prdata  (i_apb_prdata),
    .i_apb_pslverr (i_apb_pslverr),
    .o_rd_done     (apb_rd_done),
    .o_wr_done     (apb_wr_done),
    .o_rd_data     (apb_rdata)
  );

  // ==============================
  // Responses
  // ==============================

  // RAM writes never stall since they top the grant order
  assign o_dmem_wready = ram_wr || apb_wr_done;
  assign o_dmem_rvalid = ram_rvalid || apb_rd_done;
  assign o_imem_rvalid = fetch_rvalid;

  // Debug window ahead of RAM, zero elsewhere
  assign o_dmem_rdata = dmem_in_debug ? apb_rdata :
                        (dmem_in_ram ? ram_rdata : '0);
  assign o_imem_rdata = imem_in_ram ? fetch_rdata : '0;

  // tohost write, no wready goes back to the core
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      o_tohost <= '0;
    else if (i_dmem_wvalid && dmem_is_tohost)
      o_tohost <= i_dmem_wdata;
  end

endmodule

`default_nettype wire

// ==== tests/tb_mem_subsystem.sv ====
// Table-driven testbench for the memory subsystem, inputs change only on rising edges
// APB responder adds 0 to 3 wait states and never answers with an error
`timescale 1ns/10ps
`default_nettype none

module tb_mem_subsystem;

  import bus_types_pkg::*;
  import soc_map_pkg::*;

  localparam int CLK_PERIOD    = 100;
  localparam int RESET_CYCLES  = 5;
  localparam int RESP_LIMIT    = 16;
  localparam int CYCLES_PER_OP = 20;

  typedef enum logic [2:0] {
    OP_FETCH,
    OP_READ,
    OP_WRITE,
    OP_DUAL,
    OP_TOHOST,
    OP_BLOCKED
  } op_t;

  typedef struct packed {
    op_t   op;
    addr_t addr;
    word_t wdata;
    logic  debug;
    word_t exp_data;
  } entry_t;

  entry_t entries [$];

  // ==============================
  // DUT and its inputs
  // ==============================

  logic      clk;
  logic      reset_n        = 1'b0;
  addr_t     i_imem_addr    = '0;
  logic      i_imem_rready  = 1'b0;
  addr_t     i_dmem_addr    = '0;
  word_t     i_dmem_wdata   = '0;
  logic      i_dmem_wvalid  = 1'b0;
  logic      i_dmem_rready  = 1'b0;
  logic      i_apb_pready   = 1'b0;
  word_t     i_apb_prdata   = '0;
  logic      i_apb_pslverr  = 1'b0;
  logic      i_debug_mode   = 1'b0;

  word_t     o_imem_rdata;
  logic      o_imem_rvalid;
  logic      o_dmem_wready;
  word_t     o_dmem_rdata;
  logic      o_dmem_rvalid;
  apb_addr_t o_apb_paddr;
  logic      o_apb_psel;
  logic      o_apb_penable;
  logic      o_apb_pwrite;
  word_t     o_apb_pwdata;
  word_t     o_tohost;

  // Values for the next rising edge, set by the main process at falling edges
  logic      nx_reset_n     = 1'b0;
  addr_t     nx_imem_addr   = '0;
  logic      nx_imem_rready = 1'b0;
  addr_t     nx_dmem_addr   = '0;
  word_t     nx_dmem_wdata  = '0;
  logic      nx_dmem_wvalid = 1'b0;
  logic      nx_dmem_rready = 1'b0;
  logic      nx_debug       = 1'b0;

  mem_subsystem_top dut_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_imem_addr   (i_imem_addr),
    .i_imem_rready (i_imem_rready),
    .o_imem_rdata  (o_imem_rdata),
    .o_imem_rvalid (o_imem_rvalid),
    .i_dmem_addr   (i_dmem_addr),
    .i_dmem_wdata  (i_dmem_wdata),
    .i_dmem_wvalid (i_dmem_wvalid),
    .i_dmem_rready (i_dmem_rready),
    .o_dmem_wready (o_dmem_wready),
    .o_dmem_rdata  (o_dmem_rdata),
    .o_dmem_rvalid (o_dmem_rvalid),
    .o_apb_paddr   (o_apb_paddr),
    .o_apb_psel    (o_apb_psel),
    .o_apb_penable (o_apb_penable),
    .o_apb_pwrite  (o_apb_pwrite),
    .o_apb_pwdata  (o_apb_pwdata),
    .i_apb_pready  (i_apb_pready),
    .i_apb_prdata  (i_apb_prdata),
    .i_apb_pslverr (i_apb_pslverr),
    .i_debug_mode  (i_debug_mode),
    .o_tohost      (o_tohost)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Core side inputs follow the prepared values on each rising edge
  always @(posedge clk)
  begin
    reset_n       <= nx_reset_n;
    i_debug_mode  <= nx_debug;
    i_imem_addr   <= nx_imem_addr;
    i_imem_rready <= nx_imem_rready;
    i_dmem_addr   <= nx_dmem_addr;
    i_dmem_wdata  <= nx_dmem_wdata;
    i_dmem_wvalid <= nx_dmem_wvalid;
    i_dmem_rready <= nx_dmem_rready;
  end

  // ==============================
  // Helpers
  // ==============================

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Power-up contents of the debug window, unique per word
  function automatic word_t fill_word(input logic [9:0] idx);
    return {16'hDB6D, 6'b0, idx};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (expected !== actual)
    begin
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // ==============================
  // APB responder
  // ==============================

  word_t       dbg_mem [0:1023];
  logic [31:0] rng_state    = 32'h197c_f5b0;
  int          wait_left    = 0;
  int          waits_chosen = 0;
  int          apb_xfers    = 0;
  apb_addr_t   last_paddr   = '0;
  logic        last_pwrite  = 1'b0;

  always @(posedge clk)
  begin
    int w;
    if (!reset_n)
    begin
      for (w = 0; w < 1024; w++)
        dbg_mem[w[9:0]] <= fill_word(w[9:0]);
      i_apb_pready <= 1'b0;
    end
    else if (!o_apb_psel)
      i_apb_pready <= 1'b0;
    else if (!o_apb_penable)
    begin
      // End of SETUP, pick this transfer's wait states
      rng_state    = xorshift32(rng_state);
      wait_left    = int'(rng_state % 32'd4);
      waits_chosen = wait_left;
      i_apb_pready <= (wait_left == 0);
      i_apb_prdata <= dbg_mem[o_apb_paddr[11:2]];
    end
    else if (i_apb_pready)
    begin
      // Transfer completes at this edge
      if (o_apb_pwrite)
        dbg_mem[o_apb_paddr[11:2]] <= o_apb_pwdata;
      apb_xfers    <= apb_xfers + 1;
      last_paddr   <= o_apb_paddr;
      last_pwrite  <= o_apb_pwrite;
      i_apb_pready <= 1'b0;
    end
    else
    begin
      wait_left = wait_left - 1;
      if (wait_left == 0)
        i_apb_pready <= 1'b1;
    end
  end

  // ==============================
  // Stimulus table
  // ==============================

  function automatic void add_entry(input op_t op, input addr_t addr, input word_t wdata,
                                    input logic dbg, input word_t exp_data);
    entries.push_back(entry_t'{op, addr, wdata, dbg, exp_data});
  endfunction

  function automatic void load_entries();
    // Plain RAM, first and last word
    add_entry(OP_WRITE,   32'h0001_0000, 32'h1111_0001, 1'b0, '0);
    add_entry(OP_READ,    32'h0001_0000, '0,            1'b0, 32'h1111_0001);
    add_entry(OP_WRITE,   32'h0001_3FFC, 32'hA5A5_3FFC, 1'b0, '0);
    add_entry(OP_READ,    32'h0001_3FFC, '0,            1'b0, 32'hA5A5_3FFC);
    // Alias in both directions
    add_entry(OP_WRITE,   32'hFFFF_C010, 32'hC0DE_0010, 1'b0, '0);
    add_entry(OP_READ,    32'h0001_0010, '0,            1'b0, 32'hC0DE_0010);
    add_entry(OP_WRITE,   32'h0001_0020, 32'hBEEF_0020, 1'b0, '0);
    add_entry(OP_READ,    32'hFFFF_C020, '0,            1'b0, 32'hBEEF_0020);
    // Fetches see data port writes
    add_entry(OP_FETCH,   32'h0001_0020, '0,            1'b0, 32'hBEEF_0020);
    add_entry(OP_FETCH,   32'hFFFF_C010, '0,            1'b0, 32'hC0DE_0010);
    add_entry(OP_WRITE,   32'h0001_0040, 32'h600D_0040, 1'b0, '0);
    add_entry(OP_DUAL,    32'h0001_0040, '0,            1'b0, 32'h600D_0040);
    // Debug window over APB
    add_entry(OP_WRITE,   32'h0000_0200, 32'hD0D0_0200, 1'b1, '0);
    add_entry(OP_READ,    32'h0000_0200, '0,            1'b1, 32'hD0D0_0200);
    add_entry(OP_READ,    32'h0000_0300, '0,            1'b1, 32'hDB6D_00C0);
    add_entry(OP_WRITE,   32'h0000_0FFC, 32'h1234_5678, 1'b1, '0);
    add_entry(OP_READ,    32'h0000_0FFC, '0,            1'b1, 32'h1234_5678);
    add_entry(OP_WRITE,   32'h0000_0804, 32'h0F0F_0804, 1'b1, '0);
    add_entry(OP_READ,    32'h0000_0804, '0,            1'b1, 32'h0F0F_0804);
    // Window closed outside debug mode, word keeps its fill value
    add_entry(OP_BLOCKED, 32'h0000_0400, 32'hBAD0_0400, 1'b0, '0);
    add_entry(OP_READ,    32'h0000_0400, '0,            1'b1, 32'hDB6D_0100);
    // tohost, RAM untouched afterwards
    // RAM word 0x400 shares the low address bits of tohost
    add_entry(OP_WRITE,   32'h0001_1000, 32'h7A11_1000, 1'b0, '0);
    add_entry(OP_TOHOST,  TOHOST_ADDR,   32'h0000_0001, 1'b0, 32'h0000_0001);
    add_entry(OP_READ,    32'h0001_1000, '0,            1'b0, 32'h7A11_1000);
    add_entry(OP_TOHOST,  TOHOST_ADDR,   32'hCAFE_F00D, 1'b1, 32'hCAFE_F00D);
    add_entry(OP_FETCH,   32'h0001_1000, '0,            1'b1, 32'h7A11_1000);
  endfunction

  // ==============================
  // Entry execution
  // ==============================

  // Last word written to tohost, zero out of reset
  word_t tohost_model = '0;

  task automatic run_entry(input int idx);
    entry_t e;
    op_t    op;
    string  name;
    int     d_cyc;
    int     f_cyc;
    int     cycles;
    int     xfers_before;
    int     k;
    logic   in_dbg;
    logic   want_d;
    logic   want_f;
    logic   apb_op;
    e      = entries[idx];
    op     = e.op;
    name   = $sformatf("entry %0d %s at %h", idx, op.name(), e.addr);
    in_dbg = e.debug && (e.addr >= DEBUG_AREA_START) && (e.addr <= DEBUG_AREA_END);
    want_d = (op == OP_READ) || (op == OP_WRITE) || (op == OP_DUAL);
    want_f = (op == OP_FETCH) || (op == OP_DUAL);
    apb_op = in_dbg && ((op == OP_READ) || (op == OP_WRITE));
    xfers_before  = apb_xfers;
    nx_debug      = e.debug;
    nx_imem_addr  = e.addr;
    nx_dmem_addr  = e.addr;
    nx_dmem_wdata = e.wdata;
    if (op == OP_TOHOST)
    begin
      // One-cycle write, never acknowledged
      nx_dmem_wvalid = 1'b1;
      @(negedge clk);
      check_value({name, " wready"}, '0, {31'b0, o_dmem_wready});
      // Register still shows the previous word in the write cycle
      check_value({name, " tohost early"}, tohost_model, o_tohost);
      nx_dmem_wvalid = 1'b0;
      @(negedge clk);
      check_value({name, " tohost"}, e.exp_data, o_tohost);
      tohost_model = e.exp_data;
    end
    else if (op == OP_BLOCKED)
    begin
      // Held write, then held read, none may reach the bus
      for (k = 0; k < 8; k++)
      begin
        nx_dmem_wvalid = (k < 4);
        nx_dmem_rready = (k >= 4);
        @(negedge clk);
        check_value({name, " psel"}, '0, {31'b0, o_apb_psel});
        check_value({name, " response"}, '0, {30'b0, o_dmem_wready, o_dmem_rvalid});
      end
    end
    else
    begin
      nx_dmem_wvalid = (op == OP_WRITE);
      nx_dmem_rready = (op == OP_READ) || (op == OP_DUAL);
      nx_imem_rready = want_f;
      d_cyc  = -1;
      f_cyc  = -1;
      cycles = 0;
      // Cycle 0 is the first cycle that shows the request
      while ((want_d && (d_cyc < 0)) || (want_f && (f_cyc < 0)))
      begin
        @(negedge clk);
        if (want_d && (d_cyc < 0) && (o_dmem_wready || o_dmem_rvalid))
        begin
          d_cyc = cycles;
          nx_dmem_wvalid = 1'b0;
          nx_dmem_rready = 1'b0;
          if (op != OP_WRITE)
            check_value({name, " data"}, e.exp_data, o_dmem_rdata);
        end
        if (want_f && (f_cyc < 0) && o_imem_rvalid)
        begin
          f_cyc = cycles;
          nx_imem_rready = 1'b0;
          check_value({name, " fetch data"}, e.exp_data, o_imem_rdata);
        end
        cycles++;
        if (cycles > RESP_LIMIT)
          abort_run($sformatf("No response within %0d cycles for %s", RESP_LIMIT, name));
      end
      // APB takes SETUP plus ACCESS plus wait states, RAM writes are immediate
      if (want_d && in_dbg)
        check_value({name, " latency"}, 2 + waits_chosen, d_cyc);
      else if (want_d)
        check_value({name, " latency"}, (op == OP_WRITE) ? 0 : 2, d_cyc);
      if (op == OP_FETCH)
        check_value({name, " fetch latency"}, 2, f_cyc);
      else if (op == OP_DUAL)
        check_value({name, " data first"}, 32'd1, {31'b0, f_cyc > d_cyc});
    end
    nx_dmem_wvalid = 1'b0;
    nx_dmem_rready = 1'b0;
    nx_imem_rready = 1'b0;
    // Idle gap, then bus bookkeeping
    @(negedge clk);
    check_value({name, " transfers"}, xfers_before + (apb_op ? 1 : 0), apb_xfers);
    if (apb_op)
    begin
      check_value({name, " paddr"}, {19'b0, e.addr[12:0]}, {19'b0, last_paddr});
      check_value({name, " pwrite"}, {31'b0, op == OP_WRITE}, {31'b0, last_pwrite});
    end
    check_value({name, " psel idle"}, '0, {31'b0, o_apb_psel});
  endtask

  // ==============================
  // Main flow and watchdog
  // ==============================

  initial
  begin
    load_entries();
    repeat (RESET_CYCLES) @(negedge clk);
    nx_reset_n = 1'b1;
    @(negedge clk);
    @(negedge clk);
    foreach (entries[i])
      run_entry(i);
    $display("Simulation passed");
    $finish;
  end

  initial
  begin
    wait (entries.size() > 0);
    repeat (RESET_CYCLES + CYCLES_PER_OP * entries.size()) @(posedge clk);
    abort_run("Watchdog expired before the stimulus table was done");
  end

endmodule

`default_nettype wire

// ==== list.f ====
src/bus_types_pkg.sv
src/soc_map_pkg.sv
src/addr_decoder.sv
src/unified_ram.sv
src/debug_apb_master.sv
src/mem_subsystem_top.sv
tests/tb_mem_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps \
  --top-module tb_mem_subsystem -f list.f

# The simulator's own exit status is masked by tee, the log decides
./obj_dir/Vtb_mem_subsystem 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run.sh: testbench reported failure"
  exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
  echo "run.sh: simulation ended without a result"
  exit 1
fi
echo "run.sh: testbench passed"
